// File: rtl/frame_decoder_pkg.sv
package frame_decoder_pkg;

    // ------------------------------------------------------------------------
    // stream and port geometry
    // ------------------------------------------------------------------------
    localparam int data_bytes  = 4;
    localparam int num_ports   = 14;
    localparam int label_base  = 1;
    localparam int hdr_beats   = 4;
    localparam int align_depth = 2;

    typedef logic [31:0]          fill_level_t;
    typedef logic [num_ports-1:0] port_sel_t;

    // congestion marking
    localparam fill_level_t fill_alert_threshold = 32'd3000;
    localparam logic [7:0]  ecn_mark             = 8'h01;

    // keep is contiguous from byte 0
    typedef struct packed {
        logic [8*data_bytes-1:0] data;
        logic [data_bytes-1:0]   keep;
        logic                    last;
    } axis_beat_t;

    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] length_type;
        logic [7:0]  ecn;
        logic [7:0]  label;
    } frame_header_t;

endpackage

// File: rtl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
    input  logic       glb_clk,
    input  logic       glb_areset_n,
    input  logic       count_clear,
    input  logic       count_advance,
    output logic [1:0] beat_count
);
    import frame_decoder_pkg::*;

    // index of the header beat in flight, shared by capture and emit
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            beat_count <= '0;
        end else if (count_clear) begin
            beat_count <= '0;
        end else if (count_advance) begin
            beat_count <= beat_count + 2'd1;
        end
    end

endmodule

// File: rtl/frame_fsm.sv
`timescale 1ns/1ps

module frame_fsm (
    input  logic       glb_clk,
    input  logic       glb_areset_n,
    input  logic       s_tvalid,
    input  logic       s_last,
    input  logic [1:0] beat_count,
    input  logic       m_tready,
    input  logic       aligned_last,
    output logic       s_tready,
    output logic       count_clear,
    output logic       count_advance,
    output logic       capture_en,
    output logic       emit_header,
    output logic       emit_payload,
    output logic       realign_en,
    output logic       frame_active
);
    import frame_decoder_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_hdr_in,
        st_hdr_out,
        st_pay_out,
        st_drain,
        st_close
    } state_t;

    localparam logic [1:0] last_hdr_beat = 2'(hdr_beats - 1);

    state_t state;
    state_t state_next;
    logic   accept;
    logic   hdr_end;

    assign accept  = s_tvalid & s_tready;
    assign hdr_end = (beat_count == last_hdr_beat);

    // ------------------------------------------------------------------------
    // state register and transitions
    // ------------------------------------------------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (accept && !s_last) begin
                    state_next = st_hdr_in;
                end
            end
            st_hdr_in: begin
                // destination ready is looked at once, on header beat 3
                if (accept && s_last) begin
                    state_next = st_idle;
                end else if (accept && hdr_end) begin
                    state_next = m_tready ? st_hdr_out : st_drain;
                end
            end
            st_hdr_out: begin
                if (hdr_end) begin
                    state_next = st_pay_out;
                end
            end
            st_pay_out: begin
                if (aligned_last) begin
                    state_next = st_close;
                end
            end
            st_drain: begin
                if (accept && s_last) begin
                    state_next = st_idle;
                end
            end
            st_close: state_next = st_idle;
            default:  state_next = st_idle;
        endcase
    end

    // ------------------------------------------------------------------------
    // datapath steering
    // ------------------------------------------------------------------------
    assign capture_en    = accept & ((state == st_idle) | (state == st_hdr_in));
    assign emit_header   = (state == st_hdr_out);
    assign emit_payload  = (state == st_pay_out);
    assign realign_en    = emit_header | emit_payload;
    assign frame_active  = emit_header | emit_payload | (state == st_close);
    assign count_advance = capture_en | emit_header;
    assign count_clear   = (capture_en & (s_last | hdr_end)) | (emit_header & hdr_end);

    // input ready drops once last is in, back up when output is done
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            s_tready <= 1'b0;
        end else if (accept && s_last) begin
            s_tready <= 1'b0;
        end else if (state == st_idle || state == st_close) begin
            s_tready <= 1'b1;
        end
    end

endmodule

// File: rtl/header_capture.sv
`timescale 1ns/1ps

module header_capture (
    input  logic                            glb_clk,
    input  logic                            glb_areset_n,
    input  logic                            capture_en,
    input  logic [1:0]                      beat_count,
    input  logic [31:0]                     s_data,
    input  frame_decoder_pkg::fill_level_t  fill_levels [frame_decoder_pkg::num_ports],
    input  logic                            frame_active,
    output frame_decoder_pkg::frame_header_t header,
    output frame_decoder_pkg::port_sel_t    port_sel
);
    import frame_decoder_pkg::*;

    localparam int idx_w = $clog2(num_ports);

    logic [47:0]      dst_mac;
    logic [47:0]      src_mac;
    logic [15:0]      length_type;
    logic [7:0]       ecn_rx;
    logic [7:0]       label;
    logic [7:0]       port_off;
    logic             label_ok;
    logic [idx_w-1:0] port_idx;
    fill_level_t      port_fill;
    logic             congested;

    // ------------------------------------------------------------------------
    // field capture, one header beat per accept
    // ------------------------------------------------------------------------
    always_ff @(posedge glb_clk) begin
        if (capture_en) begin
            case (beat_count)
                2'd0: dst_mac[31:0] <= s_data;
                2'd1: begin
                    dst_mac[47:32] <= s_data[15:0];
                    src_mac[15:0]  <= s_data[31:16];
                end
                2'd2: src_mac[47:16] <= s_data;
                default: begin
                    length_type <= s_data[15:0];
                    ecn_rx      <= s_data[23:16];
                end
            endcase
        end
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            label <= '0;
        end else if (capture_en && beat_count == 2'd3) begin
            label <= s_data[31:24];
        end
    end

    // ------------------------------------------------------------------------
    // port decode and ECN marking
    // ------------------------------------------------------------------------
    // labels below base wrap to a large offset
    assign port_off  = label - 8'(label_base);
    assign label_ok  = (port_off < 8'(num_ports));
    assign port_idx  = port_off[idx_w-1:0];
    assign port_fill = label_ok ? fill_levels[port_idx] : '0;
    assign congested = label_ok && (port_fill > fill_alert_threshold);

    assign port_sel = (label_ok && frame_active) ? (port_sel_t'(1) << port_idx) : '0;

    assign header.dst_mac     = dst_mac;
    assign header.src_mac     = src_mac;
    assign header.length_type = length_type;
    assign header.ecn         = congested ? ecn_mark : ecn_rx;
    assign header.label       = label;

endmodule

// File: rtl/payload_realigner.sv
`timescale 1ns/1ps

module payload_realigner (
    input  logic                          glb_clk,
    input  logic                          glb_areset_n,
    input  logic                          realign_en,
    input  logic                          s_tvalid,
    input  frame_decoder_pkg::axis_beat_t s_beat,
    output logic [7:0]                    l0,
    output frame_decoder_pkg::axis_beat_t aligned,
    output logic                          aligned_valid,
    output logic                          aligned_last
);
    import frame_decoder_pkg::*;

    logic                      have_l0;
    logic                      tail_pend;
    logic                      tail_done;
    logic                      take;
    logic [8*data_bytes-9:0]   upper;
    logic [data_bytes-1:0]     tail_keep;
    axis_beat_t                join_beat;
    logic                      join_valid;
    axis_beat_t                dly_beat [align_depth];
    logic [align_depth-1:0]    dly_valid;

    // nothing is taken once last has been seen
    assign take = realign_en & s_tvalid & ~tail_done & ~tail_pend;

    // ------------------------------------------------------------------------
    // byte shift control
    // ------------------------------------------------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            have_l0    <= 1'b0;
            tail_pend  <= 1'b0;
            tail_done  <= 1'b0;
            join_valid <= 1'b0;
        end else if (!realign_en) begin
            have_l0    <= 1'b0;
            tail_pend  <= 1'b0;
            tail_done  <= 1'b0;
            join_valid <= 1'b0;
        end else begin
            join_valid <= 1'b0;
            if (tail_pend) begin
                // closing beat with the leftover bytes
                join_valid <= 1'b1;
                tail_pend  <= 1'b0;
                tail_done  <= 1'b1;
            end else if (take && !have_l0) begin
                have_l0 <= 1'b1;
            end else if (take) begin
                join_valid <= 1'b1;
                if (s_beat.last && s_beat.keep[1]) begin
                    tail_pend <= 1'b1;
                end else if (s_beat.last) begin
                    tail_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge glb_clk) begin
        if (tail_pend) begin
            join_beat.data <= {8'h00, upper};
            join_beat.keep <= tail_keep;
            join_beat.last <= 1'b1;
        end else if (take && have_l0) begin
            join_beat.data <= {s_beat.data[7:0], upper};
            join_beat.keep <= '1;
            join_beat.last <= s_beat.last & ~s_beat.keep[1];
            upper          <= s_beat.data[8*data_bytes-1:8];
            tail_keep      <= {1'b0, s_beat.keep[data_bytes-1:1]};
        end else if (take) begin
            l0    <= s_beat.data[7:0];
            upper <= s_beat.data[8*data_bytes-1:8];
        end
    end

    // ------------------------------------------------------------------------
    // delay line behind the header words
    // ------------------------------------------------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            dly_valid <= '0;
        end else begin
            dly_valid <= {dly_valid[align_depth-2:0], join_valid};
        end
    end

    always_ff @(posedge glb_clk) begin
        dly_beat[0] <= join_beat;
        for (int i = 1; i < align_depth; i++) begin
            dly_beat[i] <= dly_beat[i-1];
        end
    end

    assign aligned       = dly_beat[align_depth-1];
    assign aligned_valid = dly_valid[align_depth-1];
    assign aligned_last  = aligned_valid & aligned.last;

endmodule

// File: rtl/frame_emitter.sv
`timescale 1ns/1ps

module frame_emitter (
    input  logic                            glb_clk,
    input  logic                            glb_areset_n,
    input  logic                            emit_header,
    input  logic                            emit_payload,
    input  logic [1:0]                      beat_count,
    input  frame_decoder_pkg::frame_header_t header,
    input  logic [7:0]                      l0,
    input  frame_decoder_pkg::axis_beat_t   aligned,
    output logic                            m_tvalid,
    output frame_decoder_pkg::axis_beat_t   m_beat
);
    import frame_decoder_pkg::*;

    logic [8*data_bytes-1:0] hdr_word;

    // rebuilt header, L0 moves up into word 3
    always_comb begin
        case (beat_count)
            2'd0:    hdr_word = header.dst_mac[31:0];
            2'd1:    hdr_word = {header.src_mac[15:0], header.dst_mac[47:32]};
            2'd2:    hdr_word = header.src_mac[47:16];
            default: hdr_word = {l0, header.ecn, header.length_type};
        endcase
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            m_tvalid <= 1'b0;
            m_beat   <= '0;
        end else if (emit_header) begin
            m_tvalid    <= 1'b1;
            m_beat.data <= hdr_word;
            m_beat.keep <= '1;
            m_beat.last <= 1'b0;
        end else if (emit_payload) begin
            m_tvalid <= 1'b1;
            m_beat   <= aligned;
        end else begin
            m_tvalid <= 1'b0;
            m_beat   <= '0;
        end
    end

endmodule

// File: rtl/frame_decoder.sv
`timescale 1ns/1ps

module frame_decoder (
    input  logic                           glb_clk,
    input  logic                           glb_areset_n,
    input  logic                           s_tvalid,
    output logic                           s_tready,
    input  frame_decoder_pkg::axis_beat_t  s_beat,
    output logic                           m_tvalid,
    input  logic                           m_tready,
    output frame_decoder_pkg::axis_beat_t  m_beat,
    input  frame_decoder_pkg::fill_level_t fill_levels [frame_decoder_pkg::num_ports],
    output frame_decoder_pkg::port_sel_t   port_sel
);
    import frame_decoder_pkg::*;

    logic          count_clear;
    logic          count_advance;
    logic          capture_en;
    logic          emit_header;
    logic          emit_payload;
    logic          realign_en;
    logic          frame_active;
    logic [1:0]    beat_count;
    frame_header_t header;
    logic [7:0]    l0;
    axis_beat_t    aligned;
    logic          aligned_last;

    frame_fsm u_fsm (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_tvalid     (s_tvalid),
        .s_last       (s_beat.last),
        .beat_count   (beat_count),
        .m_tready     (m_tready),
        .aligned_last (aligned_last),
        .s_tready     (s_tready),
        .count_clear  (count_clear),
        .count_advance(count_advance),
        .capture_en   (capture_en),
        .emit_header  (emit_header),
        .emit_payload (emit_payload),
        .realign_en   (realign_en),
        .frame_active (frame_active)
    );

    beat_counter u_counter (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .count_clear  (count_clear),
        .count_advance(count_advance),
        .beat_count   (beat_count)
    );

    header_capture u_capture (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .capture_en   (capture_en),
        .beat_count   (beat_count),
        .s_data       (s_beat.data),
        .fill_levels  (fill_levels),
        .frame_active (frame_active),
        .header       (header),
        .port_sel     (port_sel)
    );

    payload_realigner u_realigner (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .realign_en   (realign_en),
        .s_tvalid     (s_tvalid),
        .s_beat       (s_beat),
        .l0           (l0),
        .aligned      (aligned),
        .aligned_valid(),
        .aligned_last (aligned_last)
    );

    frame_emitter u_emitter (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .emit_header  (emit_header),
        .emit_payload (emit_payload),
        .beat_count   (beat_count),
        .header       (header),
        .l0           (l0),
        .aligned      (aligned),
        .m_tvalid     (m_tvalid),
        .m_beat       (m_beat)
    );

endmodule

// File: tb/frame_decoder_properties.sv
`timescale 1ns/1ps

module frame_decoder_properties (
    input logic                          glb_clk,
    input logic                          glb_areset_n,
    input logic                          s_tvalid,
    input logic                          s_tready,
    input frame_decoder_pkg::axis_beat_t s_beat,
    input logic                          m_tvalid,
    input frame_decoder_pkg::port_sel_t  port_sel,
    input logic                          emit_header,
    input logic                          emit_payload
);
    import frame_decoder_pkg::*;

    int fail_count = 0;

    // no valid gaps between the first beat and last
    a_valid_held: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        (s_tvalid && s_tready && !s_beat.last) |=> s_tvalid)
    else begin
        fail_count++;
        $error("s_tvalid dropped inside a frame");
    end

    a_sel_onehot: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        $onehot0(port_sel))
    else begin
        fail_count++;
        $error("port_sel has more than one bit set");
    end

    // output only shows up with input open while the emit phases run
    a_out_phase: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        (m_tvalid && s_tready) |-> (emit_header || emit_payload))
    else begin
        fail_count++;
        $error("m_tvalid high with s_tready high outside the emit phases");
    end

endmodule

// File: tb/tb_frame_decoder.sv
`timescale 1ns/1ps

module tb_frame_decoder;
    import frame_decoder_pkg::*;

    localparam int mem_depth = 512;

    logic        glb_clk;
    logic        glb_areset_n;
    logic        s_tvalid;
    logic        s_tready;
    axis_beat_t  s_beat;
    logic        m_tvalid;
    logic        m_tready;
    axis_beat_t  m_beat;
    fill_level_t fill_levels [num_ports];
    port_sel_t   port_sel;

    logic [31:0] tdata [mem_depth];
    int          rd_ptr;
    int          num_frames;
    int          cycle;
    int          cycle_limit;
    int          hdr_done_cycle;
    int          last_in_cycle;
    logic        abort_watch;
    port_sel_t   exp_sel;
    integer      seed;
    axis_beat_t  in_q [$];
    axis_beat_t  exp_q [$];

    frame_decoder dut (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .s_beat       (s_beat),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_beat       (m_beat),
        .fill_levels  (fill_levels),
        .port_sel     (port_sel)
    );

    bind frame_decoder frame_decoder_properties u_props (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .s_beat       (s_beat),
        .m_tvalid     (m_tvalid),
        .port_sel     (port_sel),
        .emit_header  (emit_header),
        .emit_payload (emit_payload)
    );

    initial begin
        glb_clk = 1'b0;
        forever begin
            #2 glb_clk = ~glb_clk;
        end
    end

    always @(posedge glb_clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: the test ran out of time after %0d cycles", cycle);
            $display("Simulation finished: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic axis_beat_t next_beat();
        axis_beat_t b;
        b.data = tdata[rd_ptr];
        b.keep = tdata[rd_ptr+1][3:0];
        b.last = tdata[rd_ptr+2][0];
        rd_ptr += 3;
        return b;
    endfunction

    task automatic drive_frame();
        foreach (in_q[n]) begin
            @(negedge glb_clk);
            s_tvalid = 1'b1;
            s_beat   = in_q[n];
            while (!s_tready) begin
                @(negedge glb_clk);
            end
            // cycle count just after the accepting edge
            if (n == hdr_beats - 1) begin
                hdr_done_cycle = cycle + 1;
            end
            if (in_q[n].last) begin
                last_in_cycle = cycle + 1;
            end
        end
        @(negedge glb_clk);
        s_tvalid = 1'b0;
        s_beat   = '0;
    endtask

    task automatic watch_output();
        @(negedge glb_clk);
        while (!m_tvalid) begin
            @(negedge glb_clk);
        end
        check("first output cycle", cycle, hdr_done_cycle + 1);
        foreach (exp_q[k]) begin
            if (k > 0) begin
                @(negedge glb_clk);
            end
            check("m_tvalid", m_tvalid, 1'b1);
            check("m_beat.data", m_beat.data, exp_q[k].data);
            check("m_beat.keep", m_beat.keep, exp_q[k].keep);
            check("m_beat.last", m_beat.last, exp_q[k].last);
            check("port_sel", port_sel, exp_sel);
            check("s_tready", s_tready, cycle < last_in_cycle);
        end
        @(negedge glb_clk);
        check("m_tvalid", m_tvalid, 1'b0);
        check("port_sel", port_sel, '0);
        check("s_tready", s_tready, 1'b1);
    endtask

    // aborted frame leaves output and port select quiet
    always @(negedge glb_clk) begin
        if (abort_watch) begin
            check("m_tvalid", m_tvalid, 1'b0);
            check("port_sel", port_sel, '0);
        end
    end

    // a bound assertion failure ends the run at once
    always @(negedge glb_clk) begin
        if (dut.u_props.fail_count != 0) begin
            $display("a bound assertion failed in frame_decoder_properties");
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first assertion failure");
        end
    end

    // ------------------------------------------------------------------------
    // frame sequence from the data file
    // ------------------------------------------------------------------------
    initial begin
        axis_beat_t  b;
        logic [7:0]  label;
        fill_level_t fill;
        logic        mready;
        seed         = 92815;
        cycle        = 0;
        glb_areset_n = 1'b0;
        s_tvalid     = 1'b0;
        s_beat       = '0;
        m_tready     = 1'b0;
        abort_watch  = 1'b0;
        foreach (fill_levels[p]) begin
            fill_levels[p] = '0;
        end
        $readmemh("tb/frame_decoder_testdata.txt", tdata);
        num_frames  = tdata[0];
        rd_ptr      = 1;
        cycle_limit = 40 * num_frames + 100;
        repeat (4) @(posedge glb_clk);
        @(negedge glb_clk);
        glb_areset_n = 1'b1;

        for (int f = 0; f < num_frames; f++) begin
            label  = tdata[rd_ptr][7:0];
            fill   = tdata[rd_ptr+1];
            mready = tdata[rd_ptr+2][0];
            rd_ptr += 3;
            in_q.delete();
            exp_q.delete();
            do begin
                b = next_beat();
                in_q.push_back(b);
            end while (!b.last);

            // other ports get noise, only the labelled port is set
            foreach (fill_levels[p]) begin
                fill_levels[p] = $random(seed);
            end
            exp_sel = '0;
            if (label >= label_base && label < label_base + num_ports) begin
                fill_levels[label - label_base] = fill;
                exp_sel[label - label_base]     = 1'b1;
            end
            m_tready      = mready;
            last_in_cycle = 32'h7fff_ffff;

            if (mready) begin
                do begin
                    b = next_beat();
                    exp_q.push_back(b);
                end while (!b.last);
                fork
                    drive_frame();
                    watch_output();
                join
            end else begin
                abort_watch = 1'b1;
                drive_frame();
                check("s_tready", s_tready, 1'b0);
                @(negedge glb_clk);
                check("s_tready", s_tready, 1'b1);
                abort_watch = 1'b0;
            end
        end

        @(negedge glb_clk);
        if (dut.u_props.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("%0d bound assertion failures", dut.u_props.fail_count);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/frame_decoder_pkg.sv
rtl/beat_counter.sv
rtl/frame_fsm.sv
rtl/header_capture.sv
rtl/payload_realigner.sv
rtl/frame_emitter.sv
rtl/frame_decoder.sv
tb/frame_decoder_properties.sv
tb/tb_frame_decoder.sv

// File: Bender.yml
package:
  name: frame_decoder

sources:
  - rtl/frame_decoder_pkg.sv
  - rtl/beat_counter.sv
  - rtl/frame_fsm.sv
  - rtl/header_capture.sv
  - rtl/payload_realigner.sv
  - rtl/frame_emitter.sv
  - rtl/frame_decoder.sv
  - target: simulation
    files:
      - tb/frame_decoder_properties.sv
      - tb/tb_frame_decoder.sv

// File: tb/frame_decoder_testdata.txt
// first word: frame count; per frame: label fill_level m_tready (fill goes to the labelled port)
// then input beats up to last, then expected output beats if m_tready is 1
// each beat is a triple: data keep last
7
01 00000bb8 1
a0a1a2a3 f 0 b0b1b2b3 f 0 c0c1c2c3 f 0 01020800 f 0 44332211 f 0 00000055 1 1
a0a1a2a3 f 0 b0b1b2b3 f 0 c0c1c2c3 f 0 11020800 f 0 55443322 f 1
07 00000bb9 1
d0d1d2d3 f 0 e0e1e2e3 f 0 f0f1f2f3 f 0 070286dd f 0 88776655 f 0 0000aa99 3 1
d0d1d2d3 f 0 e0e1e2e3 f 0 f0f1f2f3 f 0 550186dd f 0 99887766 f 0 000000aa 1 1
0e 00000000 1
01020304 f 0 05060708 f 0 090a0b0c f 0 0e030806 f 0 13121110 f 0 00171615 7 1
01020304 f 0 05060708 f 0 090a0b0c f 0 10030806 f 0 15131211 f 0 00001716 3 1
00 ffffffff 1
21222324 f 0 25262728 f 0 292a2b2c f 0 00020800 f 0 33323130 f 0 37363534 f 1
21222324 f 0 25262728 f 0 292a2b2c f 0 30020800 f 0 34333231 f 0 00373635 7 1
0f ffffffff 1
41424344 f 0 45464748 f 0 494a4b4c f 0 0f0288b5 f 0 53525150 f 0 00000054 1 1
41424344 f 0 45464748 f 0 494a4b4c f 0 500288b5 f 0 54535251 f 1
07 ffffffff 0
61626364 f 0 65666768 f 0 696a6b6c f 0 07020800 f 0 73727170 f 0 00007574 3 1
03 00000bb9 1
81828384 f 0 85868788 f 0 898a8b8c f 0 03000800 f 0 93929190 f 0 97969594 f 0 00009998 3 1
81828384 f 0 85868788 f 0 898a8b8c f 0 90010800 f 0 94939291 f 0 98979695 f 0 00000099 1 1
